// File: common/vec_norm_pkg.sv
`default_nettype none

package vec_norm_pkg;

    // signed Q8.24 scalar
    // 8 integer bits incl. sign, 24 fraction bits
    typedef logic signed [31:0] fixed_t;

    // one 3-D vector, x in the top word
    typedef struct packed {
        fixed_t x;
        fixed_t y;
        fixed_t z;
    } vec3_t;

    // vector plus its degenerate flag
    // carried through the delay line beside the magnitude path
    typedef struct packed {
        vec3_t vec;
        logic  degenerate;
    } vec_tagged_t;

    // number of fraction bits in the Q8.24 format
    localparam int FRAC_BITS = 24;

    // 1.0 in Q8.24
    localparam fixed_t FP_ONE = 32'sh0100_0000;

    // degenerate threshold on the sum of squares, 2^-8
    // also the lowest leading-one position the inverse sqrt handles
    localparam fixed_t MIN_MAG_SQ = 32'sh0001_0000;

    // Q8.24 multiply
    // full 64-bit signed product, then drop the extra fraction bits
    // plain truncation toward minus infinity, no rounding
    function automatic fixed_t fp_mul(
        input fixed_t a,
        input fixed_t b
    );
        logic signed [63:0] prod;
        prod = a * b;
        // keep bits [FRAC_BITS+31:FRAC_BITS]
        return fixed_t'(prod >>> FRAC_BITS);
    endfunction

endpackage

`default_nettype wire

// File: verilog/sum_of_squares.sv
`timescale 1ns/1ps
`default_nettype none

module sum_of_squares (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       in_valid,
    input  vec_norm_pkg::vec3_t        in_vec,
    output logic                       out_valid,
    output vec_norm_pkg::fixed_t       out_mag_sq,
    output vec_norm_pkg::vec_tagged_t  out_tagged
);

    // 8.0 in Q8.24
    localparam vec_norm_pkg::fixed_t COMP_LIM = 32'sh0800_0000;

    // per-component squares are never negative
    vec_norm_pkg::fixed_t sq_x;
    vec_norm_pkg::fixed_t sq_y;
    vec_norm_pkg::fixed_t sq_z;
    vec_norm_pkg::fixed_t sum_sq;
    logic                 tiny;

    always_comb begin
        sq_x = vec_norm_pkg::fp_mul(in_vec.x, in_vec.x);
        sq_y = vec_norm_pkg::fp_mul(in_vec.y, in_vec.y);
        sq_z = vec_norm_pkg::fp_mul(in_vec.z, in_vec.z);
        // sum reaches 192 so bit 31 is magnitude and not sign
        sum_sq = sq_x + sq_y + sq_z;
        // unsigned compare for the same reason
        tiny = $unsigned(sum_sq) < $unsigned(vec_norm_pkg::MIN_MAG_SQ);
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            out_valid  <= 1'b0;
            out_mag_sq <= '0;
            out_tagged <= '0;
        end else begin
            out_valid <= in_valid;
            // data only moves on a strobe
            if (in_valid) begin
                out_mag_sq            <= sum_sq;
                out_tagged.vec        <= in_vec;
                out_tagged.degenerate <= tiny;
            end
        end
    end

    // components below 8.0 keep the sum inside 32 bits
    a_input_range : assert property (
        @(posedge clk) disable iff (!rst)
        in_valid |-> (in_vec.x > -COMP_LIM) && (in_vec.x < COMP_LIM)
            && (in_vec.y > -COMP_LIM) && (in_vec.y < COMP_LIM)
            && (in_vec.z > -COMP_LIM) && (in_vec.z < COMP_LIM)
    );

endmodule

`default_nettype wire

// File: inv_sqrt/invsqrt_rom.sv
`timescale 1ns/1ps
`default_nettype none

module invsqrt_rom #(
    parameter int ROM_ADDR_BITS = 12
) (
    input  logic                      clk,
    input  logic                      en,
    input  logic [ROM_ADDR_BITS-1:0]  addr,
    output vec_norm_pkg::fixed_t      data,
    output logic                      valid
);

    localparam int DEPTH = 1 << ROM_ADDR_BITS;
    // bins split 0.5..1.0 evenly
    localparam real BIN_W = 0.5 / DEPTH;

    vec_norm_pkg::fixed_t rom_mem [0:DEPTH-1];

    // fill once at elaboration
    // each entry is 1/sqrt of its bin midpoint
    // values land in (1.0, 1.414]
    initial begin
        real mid;
        real est;
        for (int a = 0; a < DEPTH; a++) begin
            mid = 0.5 + (real'(a) + 0.5) * BIN_W;
            est = (2.0 ** vec_norm_pkg::FRAC_BITS) / $sqrt(mid);
            // truncate to Q8.24
            rom_mem[a] = vec_norm_pkg::fixed_t'($rtoi(est));
        end
    end

    // registered read
    // valid follows en by one cycle
    always_ff @(posedge clk) begin
        valid <= en;
        if (en) begin
            data <= rom_mem[addr];
        end
    end

endmodule

`default_nettype wire

// File: inv_sqrt/inv_sqrt.sv
`timescale 1ns/1ps
`default_nettype none

module inv_sqrt #(
    parameter int ROM_ADDR_BITS = 12
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  valid_in,
    input  vec_norm_pkg::fixed_t  x,
    output logic                  valid_out,
    output vec_norm_pkg::fixed_t  inv_sqrt
);

    localparam int W = $bits(vec_norm_pkg::fixed_t);
    // bit position of 0.5 in Q8.24
    localparam int HALF_BIT = vec_norm_pkg::FRAC_BITS - 1;
    // lowest leading one still handled, matches the degenerate threshold
    localparam int LEAD_LO = $clog2(vec_norm_pkg::MIN_MAG_SQ);

    // stage 0, combinational normalization
    logic                         lead_found;
    int                           lead_pos;
    vec_norm_pkg::fixed_t         norm_next;
    logic signed [4:0]            exp_next;

    // stage 1 registers
    logic                         valid_s1;
    logic [ROM_ADDR_BITS-1:0]     addr_s1;
    logic signed [4:0]            exp_s1;

    // stage 2, ROM output and delayed exponent
    logic                         valid_s2;
    vec_norm_pkg::fixed_t         rom_data;
    logic signed [4:0]            exp_s2;
    vec_norm_pkg::fixed_t         scale;

    // priority encoder, highest set bit wins
    // x read as unsigned, sums of squares reach past 128
    always_comb begin
        lead_found = 1'b0;
        lead_pos   = 0;
        for (int i = LEAD_LO; i < W; i++) begin
            if (x[i]) begin
                lead_found = 1'b1;
                lead_pos   = i;
            end
        end
        // below range falls to 1.0 with no scaling
        norm_next = vec_norm_pkg::FP_ONE;
        exp_next  = '0;
        if (lead_found) begin
            // move the leading one onto the 0.5 bit
            if (lead_pos >= HALF_BIT) begin
                norm_next = x >> (lead_pos - HALF_BIT);
            end else begin
                norm_next = x << (HALF_BIT - lead_pos);
            end
            // x = norm * 2^exp, exp in -7..8
            exp_next = 5'(lead_pos - HALF_BIT);
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_s1 <= 1'b0;
            addr_s1  <= '0;
            exp_s1   <= '0;
            exp_s2   <= '0;
        end else begin
            valid_s1 <= valid_in;
            if (valid_in) begin
                // fraction bits just below the leading one
                addr_s1 <= norm_next[HALF_BIT-1 -: ROM_ADDR_BITS];
                exp_s1  <= exp_next;
            end
            // exponent waits out the ROM read
            if (valid_s1) begin
                exp_s2 <= exp_s1;
            end
        end
    end

    invsqrt_rom #(
        .ROM_ADDR_BITS(ROM_ADDR_BITS)
    ) u_rom (
        .clk   (clk),
        .en    (valid_s1),
        .addr  (addr_s1),
        .data  (rom_data),
        .valid (valid_s2)
    );

    // 1/sqrt(x) = rom(norm) * 2^(-exp/2)
    // odd exponents need the sqrt(2) steps
    always_comb begin
        case (exp_s2)
            5'sd8:   scale = 32'sh0010_0000;
            5'sd7:   scale = 32'sh0016_A09E;
            5'sd6:   scale = 32'sh0020_0000;
            5'sd5:   scale = 32'sh002D_413C;
            5'sd4:   scale = 32'sh0040_0000;
            5'sd3:   scale = 32'sh005A_8279;
            5'sd2:   scale = 32'sh0080_0000;
            5'sd1:   scale = 32'sh00B5_04F3;
            -5'sd1:  scale = 32'sh016A_09E6;
            -5'sd2:  scale = 32'sh0200_0000;
            -5'sd3:  scale = 32'sh02D4_13CC;
            -5'sd4:  scale = 32'sh0400_0000;
            -5'sd5:  scale = 32'sh05A8_2799;
            -5'sd6:  scale = 32'sh0800_0000;
            -5'sd7:  scale = 32'sh0B50_4F33;
            default: scale = vec_norm_pkg::FP_ONE;
        endcase
    end

    // stage 3, scaled estimate
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_out <= 1'b0;
            inv_sqrt  <= '0;
        end else begin
            valid_out <= valid_s2;
            if (valid_s2) begin
                // at most 16, fits Q8.24
                inv_sqrt <= vec_norm_pkg::fp_mul(rom_data, scale);
            end
        end
    end

    // three-stage latency across the ROM boundary
    a_latency_three : assert property (
        @(posedge clk) disable iff (!rst)
        valid_out == $past(valid_in, 3)
    );

endmodule

`default_nettype wire

// File: verilog/vec_delay.sv
`timescale 1ns/1ps
`default_nettype none

module vec_delay (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       in_valid,
    input  vec_norm_pkg::vec_tagged_t  in_tagged,
    output vec_norm_pkg::vec_tagged_t  out_tagged
);

    // matches the inv_sqrt latency
    localparam int DEPTH = 3;

    vec_norm_pkg::vec_tagged_t stage_q [0:DEPTH-1];
    // valid beside each stage but the last
    logic [DEPTH-2:0]          valid_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            valid_q <= {valid_q[DEPTH-3:0], in_valid};
            // stage loads only under its own valid
            // keeps the wide word quiet on idle cycles
            if (in_valid) begin
                stage_q[0] <= in_tagged;
            end
            for (int i = 1; i < DEPTH; i++) begin
                if (valid_q[i-1]) begin
                    stage_q[i] <= stage_q[i-1];
                end
            end
        end
    end

    assign out_tagged = stage_q[DEPTH-1];

endmodule

`default_nettype wire

// File: verilog/vec_scale.sv
`timescale 1ns/1ps
`default_nettype none

module vec_scale (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       in_valid,
    input  vec_norm_pkg::fixed_t       rsqrt,
    input  vec_norm_pkg::vec_tagged_t  in_tagged,
    output logic                       out_valid,
    output vec_norm_pkg::vec3_t        out_vec,
    output logic                       out_degenerate
);

    vec_norm_pkg::vec3_t scaled;

    // signed component times 1/|v|
    always_comb begin
        scaled.x = vec_norm_pkg::fp_mul(in_tagged.vec.x, rsqrt);
        scaled.y = vec_norm_pkg::fp_mul(in_tagged.vec.y, rsqrt);
        scaled.z = vec_norm_pkg::fp_mul(in_tagged.vec.z, rsqrt);
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            out_valid      <= 1'b0;
            out_vec        <= '0;
            out_degenerate <= 1'b0;
        end else begin
            out_valid <= in_valid;
            // flag only lives for the strobe cycle
            out_degenerate <= in_valid & in_tagged.degenerate;
            if (in_valid) begin
                // rsqrt is meaningless for tiny inputs
                // so the vector is forced to zero
                if (in_tagged.degenerate) begin
                    out_vec <= '0;
                end else begin
                    out_vec <= scaled;
                end
            end
        end
    end

    // a positive reciprocal keeps the sign of every component
    a_rsqrt_positive : assert property (
        @(posedge clk) disable iff (!rst)
        in_valid |-> rsqrt > 0
    );

endmodule

`default_nettype wire

// File: verilog/vec_normalize.sv
`timescale 1ns/1ps
`default_nettype none

module vec_normalize #(
    parameter int ROM_ADDR_BITS = 12
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  vec_norm_pkg::vec3_t  in_vec,
    output logic                 out_valid,
    output vec_norm_pkg::vec3_t  out_vec,
    output logic                 out_degenerate
);

    // magnitude path
    logic                      mag_sq_valid;
    vec_norm_pkg::fixed_t      mag_sq;
    logic                      rsqrt_valid;
    vec_norm_pkg::fixed_t      rsqrt;

    // vector path
    vec_norm_pkg::vec_tagged_t sos_tagged;
    vec_norm_pkg::vec_tagged_t aligned_vec;

    // cycle 1, sum of squares and degenerate flag
    sum_of_squares u_sos (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_vec     (in_vec),
        .out_valid  (mag_sq_valid),
        .out_mag_sq (mag_sq),
        .out_tagged (sos_tagged)
    );

    // cycles 2 to 4, reciprocal magnitude
    inv_sqrt #(
        .ROM_ADDR_BITS(ROM_ADDR_BITS)
    ) u_inv_sqrt (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (mag_sq_valid),
        .x         (mag_sq),
        .valid_out (rsqrt_valid),
        .inv_sqrt  (rsqrt)
    );

    // vector waits the same three cycles
    vec_delay u_delay (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (mag_sq_valid),
        .in_tagged  (sos_tagged),
        .out_tagged (aligned_vec)
    );

    // cycle 5, scaled output
    vec_scale u_scale (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (rsqrt_valid),
        .rsqrt          (rsqrt),
        .in_tagged      (aligned_vec),
        .out_valid      (out_valid),
        .out_vec        (out_vec),
        .out_degenerate (out_degenerate)
    );

endmodule

`default_nettype wire

// File: verification/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
    parameter real PERIOD_NS    = 100.0,
    parameter int  RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst
);

    // free-running clock, first rising edge at half a period
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // active-low reset, released on a falling edge
    // nonblocking so same-edge samplers still see it low
    initial begin
        rst = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst <= 1'b1;
    end

endmodule

`default_nettype wire

// File: verification/tb_vec_normalize.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vec_normalize;

    localparam int  LATENCY     = 5;
    localparam int  NUM_RANDOM  = 400;
    localparam int  NUM_AXIS    = 12;
    localparam int  NUM_TINY    = 21;
    localparam int  NUM_VECTORS = NUM_RANDOM + NUM_AXIS + NUM_TINY;
    // idle cycles between strobes go up to this
    localparam int  MAX_GAP     = 3;
    localparam real PERIOD_NS   = 100.0;
    localparam real TIMEOUT_NS  = (NUM_VECTORS * (MAX_GAP + 1) + 50) * PERIOD_NS;
    // allowed error per output component
    localparam real TOL         = 0.004;
    // 8.0 is 2^27 in Q8.24 and components stay strictly inside
    localparam int  FULL_LIM    = (1 << 27) - 1;
    // about 0.034 so three squares stay below 0.9 of the threshold
    localparam int  TINY_LIM    = 570000;

    logic                 clk;
    logic                 rst;
    logic                 in_valid;
    vec_norm_pkg::vec3_t  in_vec;
    logic                 out_valid;
    vec_norm_pkg::vec3_t  out_vec;
    logic                 out_degenerate;

    // vectors in flight with the oldest first
    vec_norm_pkg::vec3_t  pending_vec[$];
    int                   pending_cycle[$];
    int                   pending_test[$];

    int          cycle_count = 0;
    int          sent = 0;
    int          checked = 0;
    int          mismatches = 0;
    int          other_errors = 0;
    logic        rst_prev = 1'b0;

    clk_gen #(
        .PERIOD_NS    (PERIOD_NS),
        .RESET_CYCLES (5)
    ) u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    vec_normalize #(
        .ROM_ADDR_BITS (12)
    ) dut0 (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .in_vec         (in_vec),
        .out_valid      (out_valid),
        .out_vec        (out_vec),
        .out_degenerate (out_degenerate)
    );

    function automatic real to_real(input vec_norm_pkg::fixed_t v);
        return $itor(v) / $itor(vec_norm_pkg::FP_ONE);
    endfunction

    function automatic real abs_real(input real r);
        return (r < 0.0) ? -r : r;
    endfunction

    function automatic string test_name(input int code);
        case (code)
            0:       return "random_accuracy";
            1:       return "axis_vector";
            default: return "degenerate_vector";
        endcase
    endfunction

    function automatic string comp_name(input int i);
        case (i)
            0:       return "x";
            1:       return "y";
            default: return "z";
        endcase
    endfunction

    // uniform integer in [-lim, lim]
    function automatic vec_norm_pkg::fixed_t rand_comp(input int lim);
        return int'($urandom % (2 * lim + 1)) - lim;
    endfunction

    // random vector whose sum of squares stays clear of the threshold band
    function automatic vec_norm_pkg::vec3_t rand_vec();
        vec_norm_pkg::vec3_t v;
        real                 s;
        s = 0.0;
        while (s < 1.1 * to_real(vec_norm_pkg::MIN_MAG_SQ)) begin
            v.x = rand_comp(FULL_LIM);
            v.y = rand_comp(FULL_LIM);
            v.z = rand_comp(FULL_LIM);
            s = to_real(v.x) ** 2 + to_real(v.y) ** 2 + to_real(v.z) ** 2;
        end
        return v;
    endfunction

    // one strobe logged with its drive cycle
    task automatic send(input vec_norm_pkg::vec3_t v, input int code);
        in_valid = 1'b1;
        in_vec   = v;
        pending_vec.push_back(v);
        pending_cycle.push_back(cycle_count);
        pending_test.push_back(code);
        sent++;
        @(negedge clk);
    endtask

    task automatic idle(input int n);
        in_valid = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    // model of one output against the oldest pending input
    task automatic check_output();
        vec_norm_pkg::vec3_t  v;
        vec_norm_pkg::fixed_t in_c[3];
        vec_norm_pkg::fixed_t out_c[3];
        int                   drive_cycle;
        int                   code;
        real                  sum_sq;
        real                  mag;
        real                  exp_c;
        real                  act_c;
        logic                 exp_degen;
        if (pending_vec.size() == 0) begin
            other_errors++;
            $display("error: out_valid at cycle %0d with no input pending", cycle_count);
            return;
        end
        v           = pending_vec.pop_front();
        drive_cycle = pending_cycle.pop_front();
        code        = pending_test.pop_front();
        checked++;
        if (cycle_count - drive_cycle != LATENCY) begin
            mismatches++;
            $display("MISMATCH %s latency: expected %0d actual %0d",
                     test_name(code), LATENCY, cycle_count - drive_cycle);
        end
        in_c[0]  = v.x;
        in_c[1]  = v.y;
        in_c[2]  = v.z;
        out_c[0] = out_vec.x;
        out_c[1] = out_vec.y;
        out_c[2] = out_vec.z;
        sum_sq = 0.0;
        for (int i = 0; i < 3; i++) begin
            sum_sq += to_real(in_c[i]) * to_real(in_c[i]);
        end
        exp_degen = sum_sq < to_real(vec_norm_pkg::MIN_MAG_SQ);
        if (out_degenerate !== exp_degen) begin
            mismatches++;
            $display("MISMATCH %s degenerate: expected %0d actual %0d",
                     test_name(code), exp_degen, out_degenerate);
        end
        mag = $sqrt(sum_sq);
        for (int i = 0; i < 3; i++) begin
            act_c = to_real(out_c[i]);
            // zero inputs and degenerate vectors give exact zeros
            if (exp_degen || in_c[i] == 0) begin
                if (out_c[i] !== 0) begin
                    mismatches++;
                    $display("MISMATCH %s %s: expected %f actual %f",
                             test_name(code), comp_name(i), 0.0, act_c);
                end
            end else begin
                exp_c = to_real(in_c[i]) / mag;
                if (abs_real(exp_c - act_c) > TOL) begin
                    mismatches++;
                    $display("MISMATCH %s %s: expected %f actual %f",
                             test_name(code), comp_name(i), exp_c, act_c);
                end
            end
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // outputs sampled mid-cycle where they are stable
    always @(negedge clk) begin
        // quiet during reset and the cycle after release
        if (!rst || !rst_prev) begin
            if (out_valid || out_degenerate) begin
                other_errors++;
                $display("error: output strobe active during reset at cycle %0d", cycle_count);
            end
        end
        if (out_degenerate && !out_valid) begin
            other_errors++;
            $display("error: out_degenerate high without out_valid at cycle %0d", cycle_count);
        end
        if (out_valid) begin
            check_output();
        end
        rst_prev = rst;
    end

    // watchdog bound covers every vector with its largest gap
    initial begin
        #(TIMEOUT_NS);
        $display("error: timeout after %0t with %0d of %0d outputs seen",
                 $time, checked, sent);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        vec_norm_pkg::vec3_t v;
        int                  mag;
        void'($urandom(32'h06aed2ae));
        in_valid = 1'b0;
        in_vec   = '0;
        wait (rst === 1'b1);
        @(negedge clk);
        // back to back and then with random gaps
        for (int n = 0; n < NUM_RANDOM; n++) begin
            send(rand_vec(), 0);
            if (n >= NUM_RANDOM / 2) begin
                idle($urandom % (MAX_GAP + 1));
            end
        end
        idle(2);
        // each axis and sign with fixed and then random magnitude
        for (int n = 0; n < NUM_AXIS; n++) begin
            v   = '0;
            mag = (n < 6) ? int'(vec_norm_pkg::FP_ONE)
                          : 1677722 + int'($urandom % (FULL_LIM - 1677722));
            if (n % 2 == 1) begin
                mag = -mag;
            end
            case ((n / 2) % 3)
                0:       v.x = mag;
                1:       v.y = mag;
                default: v.z = mag;
            endcase
            send(v, 1);
        end
        idle(2);
        // zero vector first and tiny ones after it
        send('0, 2);
        for (int n = 1; n < NUM_TINY; n++) begin
            v.x = rand_comp(TINY_LIM);
            v.y = rand_comp(TINY_LIM);
            v.z = rand_comp(TINY_LIM);
            send(v, 2);
        end
        // every output is due LATENCY cycles after its strobe
        // a late or extra strobe shows up as an unmatched output
        idle(LATENCY + 10);
        if (pending_vec.size() != 0) begin
            other_errors++;
            $display("error: %0d inputs never produced an output", pending_vec.size());
        end
        $display("summary: %0d mismatches, %0d other errors, %0d of %0d outputs checked",
                 mismatches, other_errors, checked, sent);
        if (mismatches == 0 && other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vec_normalize.f
common/vec_norm_pkg.sv
verilog/sum_of_squares.sv
inv_sqrt/invsqrt_rom.sv
inv_sqrt/inv_sqrt.sv
verilog/vec_delay.sv
verilog/vec_scale.sv
verilog/vec_normalize.sv
verification/clk_gen.sv
verification/tb_vec_normalize.sv
